// File: rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and instruction word width
`define CPU_DATA_W 16

// General purpose registers
`define CPU_REG_COUNT 16

// Data memory words, addressed by the low address bits
`define CPU_DMEM_DEPTH 64

`endif

// File: rtl/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

  // Opcode in instruction bits 15..12, codes 14 and 15 behave as NOP
  typedef enum logic [3:0] {
    opNop = 4'd0,
    opAdd = 4'd1,
    opSub = 4'd2,
    opAnd = 4'd3,
    opOr  = 4'd4,
    opNot = 4'd5,
    opLdi = 4'd6,
    opLd  = 4'd7,
    opSt  = 4'd8,
    opIn  = 4'd9,
    opOut = 4'd10,
    opJmp = 4'd11,
    opJz  = 4'd12,
    opJc  = 4'd13
  } opcodeT;

  typedef enum logic [1:0] {
    fwdReg,
    fwdExMem,
    fwdMemWb
  } fwdSelT;

  // All zero is a bubble
  typedef struct packed {
    opcodeT op;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   flagWrite;
    logic   isBranch;
    logic   isOut;
  } ctrlT;

  typedef struct packed {
    logic                   valid;
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] instr;
  } ifIdT;

  typedef struct packed {
    ctrlT                   ctrl;
    logic [3:0]             rd;
    logic [3:0]             rs;
    logic [`CPU_DATA_W-1:0] rdVal;
    logic [`CPU_DATA_W-1:0] rsVal;
    logic [`CPU_DATA_W-1:0] imm;
  } idExT;

  typedef struct packed {
    ctrlT                   ctrl;
    logic [3:0]             rd;
    logic [`CPU_DATA_W-1:0] result;
    logic [`CPU_DATA_W-1:0] storeData;
  } exMemT;

  typedef struct packed {
    logic                   regWrite;
    logic                   isOut;
    logic [3:0]             rd;
    logic [`CPU_DATA_W-1:0] value;
  } memWbT;

endpackage

// File: rtl/fetchUnit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetchUnit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall,
  input  logic                   branchTaken,
  input  logic [`CPU_DATA_W-1:0] branchTarget,
  input  logic [`CPU_DATA_W-1:0] instr,
  output logic [`CPU_DATA_W-1:0] instrAddr,
  output cpuPkg::ifIdT           ifId
);
  import cpuPkg::*;

  logic [`CPU_DATA_W-1:0] pc;

  assign instrAddr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= '0;
      ifId.valid <= 1'b0;
    end else if (branchTaken) begin
      // Redirect wins over a stall, the word in fetch is dropped
      pc         <= branchTarget;
      ifId.valid <= 1'b0;
    end else if (!stall) begin
      pc   <= pc + 1'b1;
      ifId <= '{valid: 1'b1, pc: pc, instr: instr};
    end
  end

endmodule

// File: rtl/decodeUnit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decodeUnit (
  input  logic                   clk,
  input  logic                   reset,
  input  cpuPkg::ifIdT           ifId,
  input  logic                   stall,
  input  logic                   flush,
  input  logic [`CPU_DATA_W-1:0] rdVal,
  input  logic [`CPU_DATA_W-1:0] rsVal,
  output cpuPkg::idExT           idEx
);
  import cpuPkg::*;

  ctrlT ctrl;

  always_comb begin
    ctrl = '0;
    if (ifId.valid) begin
      ctrl.op = opcodeT'(ifId.instr[15:12]);
      case (ctrl.op)
        opAdd, opSub, opAnd, opOr, opNot: begin
          ctrl.regWrite  = 1'b1;
          ctrl.flagWrite = 1'b1;
        end
        opLdi: ctrl.regWrite = 1'b1;
        // IN returns its value in the memory stage like a load
        opLd, opIn: begin
          ctrl.regWrite = 1'b1;
          ctrl.memRead  = 1'b1;
        end
        opSt: ctrl.memWrite = 1'b1;
        opOut: ctrl.isOut = 1'b1;
        opJmp, opJz, opJc: ctrl.isBranch = 1'b1;
        default: ctrl.op = opNop;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset || stall || flush) begin
      idEx.ctrl <= '0;
    end else begin
      idEx <= '{
        ctrl:  ctrl,
        rd:    ifId.instr[11:8],
        rs:    ifId.instr[7:4],
        rdVal: rdVal,
        rsVal: rsVal,
        imm:   {{(`CPU_DATA_W - 8){1'b0}}, ifId.instr[7:0]}
      };
    end
  end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [3:0]             rdAddr,
  input  logic [3:0]             rsAddr,
  input  cpuPkg::memWbT          wb,
  output logic [`CPU_DATA_W-1:0] rdVal,
  output logic [`CPU_DATA_W-1:0] rsVal
);
  import cpuPkg::*;

  logic [`CPU_DATA_W-1:0] regs [`CPU_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.regWrite) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // Same cycle write is visible to decode
  assign rdVal = (wb.regWrite && wb.rd == rdAddr) ? wb.value : regs[rdAddr];
  assign rsVal = (wb.regWrite && wb.rd == rsAddr) ? wb.value : regs[rsAddr];

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  input  cpuPkg::ifIdT   ifId,
  input  cpuPkg::idExT   idEx,
  input  cpuPkg::exMemT  exMem,
  input  cpuPkg::memWbT  memWb,
  output logic           stall,
  output cpuPkg::fwdSelT srcSel,
  output cpuPkg::fwdSelT dstSel
);
  import cpuPkg::*;

  opcodeT     decOp;
  logic [3:0] decRd;
  logic [3:0] decRs;
  logic       usesRd;
  logic       usesRs;

  // Newest producer first
  function automatic fwdSelT pickSource(logic [3:0] addr, exMemT em, memWbT mw);
    if (em.ctrl.regWrite && em.rd == addr) begin
      return fwdExMem;
    end
    if (mw.regWrite && mw.rd == addr) begin
      return fwdMemWb;
    end
    return fwdReg;
  endfunction

  assign decOp = opcodeT'(ifId.instr[15:12]);
  assign decRd = ifId.instr[11:8];
  assign decRs = ifId.instr[7:4];

  // Operands actually read by the decoding instruction
  assign usesRd = decOp inside {opAdd, opSub, opAnd, opOr, opSt, opJmp, opJz, opJc};
  assign usesRs = decOp inside {opAdd, opSub, opAnd, opOr, opNot, opLd, opSt, opOut};

  assign stall = ifId.valid && idEx.ctrl.memRead &&
                 ((usesRd && decRd == idEx.rd) || (usesRs && decRs == idEx.rd));

  assign srcSel = pickSource(idEx.rs, exMem, memWb);
  assign dstSel = pickSource(idEx.rd, exMem, memWb);

endmodule

// File: rtl/executeUnit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module executeUnit (
  input  logic                   clk,
  input  logic                   reset,
  input  cpuPkg::idExT           idEx,
  input  cpuPkg::fwdSelT         srcSel,
  input  cpuPkg::fwdSelT         dstSel,
  input  cpuPkg::memWbT          memWb,
  output logic                   branchTaken,
  output logic [`CPU_DATA_W-1:0] branchTarget,
  output cpuPkg::exMemT          exMem
);
  import cpuPkg::*;

  logic [`CPU_DATA_W-1:0] rdOp;
  logic [`CPU_DATA_W-1:0] rsOp;
  logic [`CPU_DATA_W-1:0] result;
  logic [`CPU_DATA_W:0]   sum;
  logic                   carry;
  logic                   zFlag;
  logic                   cFlag;

  // Operand forwarding
  assign rdOp = (dstSel == fwdExMem) ? exMem.result :
                (dstSel == fwdMemWb) ? memWb.value : idEx.rdVal;
  assign rsOp = (srcSel == fwdExMem) ? exMem.result :
                (srcSel == fwdMemWb) ? memWb.value : idEx.rsVal;

  always_comb begin
    sum    = '0;
    result = '0;
    carry  = 1'b0;
    case (idEx.ctrl.op)
      opAdd: begin
        sum    = {1'b0, rdOp} + {1'b0, rsOp};
        result = sum[`CPU_DATA_W-1:0];
        carry  = sum[`CPU_DATA_W];
      end
      opSub: begin
        // Top bit is the borrow
        sum    = {1'b0, rdOp} - {1'b0, rsOp};
        result = sum[`CPU_DATA_W-1:0];
        carry  = sum[`CPU_DATA_W];
      end
      opAnd: result = rdOp & rsOp;
      opOr: result = rdOp | rsOp;
      opNot: result = ~rsOp;
      opLdi: result = idEx.imm;
      opLd, opOut: result = rsOp;
      opSt: result = rdOp;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      zFlag <= 1'b0;
      cFlag <= 1'b0;
    end else if (idEx.ctrl.flagWrite) begin
      zFlag <= (result == '0);
      cFlag <= carry;
    end
  end

  // Branches see the flags left by older instructions
  assign branchTaken = idEx.ctrl.isBranch &&
                       (idEx.ctrl.op == opJmp ||
                        (idEx.ctrl.op == opJz && zFlag) ||
                        (idEx.ctrl.op == opJc && cFlag));
  assign branchTarget = rdOp;

  always_ff @(posedge clk) begin
    if (reset) begin
      exMem.ctrl <= '0;
    end else begin
      exMem <= '{ctrl: idEx.ctrl, rd: idEx.rd, result: result, storeData: rsOp};
    end
  end

endmodule

// File: rtl/memoryUnit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module memoryUnit (
  input  logic                   clk,
  input  logic                   reset,
  input  cpuPkg::exMemT          exMem,
  input  logic [`CPU_DATA_W-1:0] inport,
  output cpuPkg::memWbT          memWb,
  output logic [`CPU_DATA_W-1:0] outport,
  output logic                   outValid
);
  import cpuPkg::*;

  localparam int AddrW = $clog2(`CPU_DMEM_DEPTH);

  logic [`CPU_DATA_W-1:0] dmem [`CPU_DMEM_DEPTH];
  logic [AddrW-1:0]       addr;
  logic [`CPU_DATA_W-1:0] value;

  assign addr = exMem.result[AddrW-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (exMem.ctrl.memWrite) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  assign value = (exMem.ctrl.op == opIn) ? inport :
                 exMem.ctrl.memRead      ? dmem[addr] : exMem.result;

  always_ff @(posedge clk) begin
    if (reset) begin
      memWb.regWrite <= 1'b0;
      memWb.isOut    <= 1'b0;
    end else begin
      memWb <= '{regWrite: exMem.ctrl.regWrite, isOut: exMem.ctrl.isOut,
                 rd: exMem.rd, value: value};
    end
  end

  // Output port loads as the OUT sits in writeback
  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
    end else begin
      outValid <= memWb.isOut;
      if (memWb.isOut) begin
        outport <= memWb.value;
      end
    end
  end

endmodule

// File: rtl/pipelineCpu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module pipelineCpu (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`CPU_DATA_W-1:0] instr,
  input  logic [`CPU_DATA_W-1:0] inport,
  output logic [`CPU_DATA_W-1:0] instrAddr,
  output logic [`CPU_DATA_W-1:0] outport,
  output logic                   outValid
);
  import cpuPkg::*;

  ifIdT                   ifId;
  idExT                   idEx;
  exMemT                  exMem;
  memWbT                  memWb;
  logic                   stall;
  logic                   branchTaken;
  logic [`CPU_DATA_W-1:0] branchTarget;
  logic [`CPU_DATA_W-1:0] rdVal;
  logic [`CPU_DATA_W-1:0] rsVal;
  fwdSelT                 srcSel;
  fwdSelT                 dstSel;

  fetchUnit i_fetchUnit (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .instr(instr),
    .instrAddr(instrAddr),
    .ifId(ifId)
  );

  regFile i_regFile (
    .clk(clk),
    .reset(reset),
    .rdAddr(ifId.instr[11:8]),
    .rsAddr(ifId.instr[7:4]),
    .wb(memWb),
    .rdVal(rdVal),
    .rsVal(rsVal)
  );

  // A taken branch flushes decode as well
  decodeUnit i_decodeUnit (
    .clk(clk),
    .reset(reset),
    .ifId(ifId),
    .stall(stall),
    .flush(branchTaken),
    .rdVal(rdVal),
    .rsVal(rsVal),
    .idEx(idEx)
  );

  hazardUnit i_hazardUnit (
    .ifId(ifId),
    .idEx(idEx),
    .exMem(exMem),
    .memWb(memWb),
    .stall(stall),
    .srcSel(srcSel),
    .dstSel(dstSel)
  );

  executeUnit i_executeUnit (
    .clk(clk),
    .reset(reset),
    .idEx(idEx),
    .srcSel(srcSel),
    .dstSel(dstSel),
    .memWb(memWb),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .exMem(exMem)
  );

  memoryUnit i_memoryUnit (
    .clk(clk),
    .reset(reset),
    .exMem(exMem),
    .inport(inport),
    .memWb(memWb),
    .outport(outport),
    .outValid(outValid)
  );

endmodule

// File: sim/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuTb;
  import cpuPkg::*;

  localparam int NumProgs = 8;
  localparam int ProgWords = 256;
  localparam int RunCycles = 600;
  localparam int ResetCycles = 10;
  localparam int ClkPeriod = 20;
  // More steps than the core can retire in one run
  localparam int ModelSteps = 700;
  // Last cycle after reset whose outValid is sampled
  localparam int LastPulseCycle = RunCycles - 2;

  logic                   clk;
  logic                   reset;
  logic [`CPU_DATA_W-1:0] instr;
  logic [`CPU_DATA_W-1:0] inport;
  logic [`CPU_DATA_W-1:0] instrAddr;
  logic [`CPU_DATA_W-1:0] outport;
  logic                   outValid;

  logic [`CPU_DATA_W-1:0] prog [ProgWords];
  logic [`CPU_DATA_W-1:0] expOut [$];
  logic [31:0]            lfsr;
  bit                     running;
  int                     expCount;
  int                     outCount;

  pipelineCpu i_pipelineCpu (
    .clk(clk),
    .reset(reset),
    .instr(instr),
    .inport(inport),
    .instrAddr(instrAddr),
    .outport(outport),
    .outValid(outValid)
  );

  // Program space repeats every 256 words
  assign instr = prog[instrAddr[7:0]];

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [15:0] takeBits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
    return v;
  endfunction

  // Register operands each opcode reads
  function automatic bit readsReg(logic [15:0] w, logic [3:0] r);
    logic rdRead;
    logic rsRead;
    rdRead = w[15:12] inside {opAdd, opSub, opAnd, opOr, opSt, opJmp, opJz, opJc};
    rsRead = w[15:12] inside {opAdd, opSub, opAnd, opOr, opNot, opLd, opSt, opOut};
    return (rdRead && w[11:8] == r) || (rsRead && w[7:4] == r);
  endfunction

  task automatic failRun(string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkOut(logic [`CPU_DATA_W-1:0] got, logic [`CPU_DATA_W-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch outport: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic checkAddr(logic [`CPU_DATA_W-1:0] got, logic [`CPU_DATA_W-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch instrAddr: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic checkCount(int got, int exp);
    if (got != exp) begin
      failRun($sformatf("mismatch outValid pulses: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  // About one word in four is an OUT
  // Jumps mostly get an LDI of their target
  task automatic buildProgram();
    logic [15:0] kind;
    logic [15:0] rd;
    logic [15:0] rs;
    logic [15:0] sel;
    logic [15:0] imm;
    logic [15:0] word;
    int i;
    i = 0;
    while (i < ProgWords) begin
      kind = takeBits(4);
      rd = takeBits(3);
      rs = takeBits(3);
      sel = takeBits(4);
      imm = takeBits(8);
      if (kind < 4) begin
        word = {opOut, 4'h0, rs[3:0], 4'h0};
      end else if (kind == 4) begin
        if (sel[3:2] != 2'b00 && i < ProgWords - 1) begin
          prog[i] = {opLdi, rd[3:0], imm[7:0]};
          i++;
        end
        word = {(sel[1:0] == 2'd0) ? opJmp : (sel[1:0] == 2'd1) ? opJz : opJc,
                rd[3:0], 8'h00};
      end else if (kind < 7) begin
        word = {opLdi, rd[3:0], imm[7:0]};
      end else if (kind == 7) begin
        word = {opLd, rd[3:0], rs[3:0], 4'h0};
      end else if (kind == 8) begin
        word = {opSt, rd[3:0], rs[3:0], 4'h0};
      end else if (kind == 9) begin
        word = {opIn, rd[3:0], 8'h00};
      end else if (kind < 15) begin
        case (sel[2:0])
          3'd0, 3'd5: word = {opAdd, rd[3:0], rs[3:0], 4'h0};
          3'd1, 3'd6: word = {opSub, rd[3:0], rs[3:0], 4'h0};
          3'd2: word = {opAnd, rd[3:0], rs[3:0], 4'h0};
          3'd3: word = {opOr, rd[3:0], rs[3:0], 4'h0};
          default: word = {opNot, rd[3:0], rs[3:0], 4'h0};
        endcase
      end else begin
        word = takeBits(16);
      end
      prog[i] = word;
      i++;
    end
  endtask

  // In-order interpreter of the instruction set
  task automatic runModel(logic [`CPU_DATA_W-1:0] inVal);
    logic [15:0] regs [16];
    logic [15:0] mem [`CPU_DMEM_DEPTH];
    logic [15:0] pc;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic z;
    logic c;
    logic taken;
    int cyc;
    expOut.delete();
    expCount = 0;
    for (int k = 0; k < 16; k++) begin
      regs[k] = '0;
    end
    for (int k = 0; k < `CPU_DMEM_DEPTH; k++) begin
      mem[k] = '0;
    end
    pc = '0;
    z = 1'b0;
    c = 1'b0;
    // First word executes two cycles after reset
    cyc = 2;
    for (int step = 0; step < ModelSteps; step++) begin
      w = prog[pc[7:0]];
      a = regs[w[11:8]];
      b = regs[w[7:4]];
      pc = pc + 16'd1;
      taken = 1'b0;
      case (opcodeT'(w[15:12]))
        opAdd: begin
          regs[w[11:8]] = a + b;
          c = ({1'b0, a} + {1'b0, b}) > 17'h0ffff;
        end
        opSub: begin
          regs[w[11:8]] = a - b;
          c = a < b;
        end
        opAnd: regs[w[11:8]] = a & b;
        opOr: regs[w[11:8]] = a | b;
        opNot: regs[w[11:8]] = ~b;
        opLdi: regs[w[11:8]] = {8'h00, w[7:0]};
        opLd: regs[w[11:8]] = mem[b[5:0]];
        opSt: mem[a[5:0]] = b;
        opIn: regs[w[11:8]] = inVal;
        opOut: begin
          expOut.push_back(b);
          // Pulse lands three cycles after execute
          if (cyc + 3 <= LastPulseCycle) begin
            expCount++;
          end
        end
        opJmp: taken = 1'b1;
        opJz: taken = z;
        opJc: taken = c;
        default: ;
      endcase
      if (taken) begin
        pc = a;
      end
      if (w[15:12] inside {opAnd, opOr, opNot}) begin
        c = 1'b0;
      end
      if (w[15:12] inside {opAdd, opSub, opAnd, opOr, opNot}) begin
        z = regs[w[11:8]] == 16'h0000;
      end
      cyc = cyc + 1;
      // Two discarded words after a taken branch
      if (taken) begin
        cyc = cyc + 2;
      end
      // One stall cycle for a load-use pair
      if (w[15:12] inside {opLd, opIn} && readsReg(prog[pc[7:0]], w[11:8])) begin
        cyc = cyc + 1;
      end
    end
  endtask

  always @(negedge clk) begin
    if (running && outValid) begin
      outCount++;
      if (expOut.size() == 0) begin
        failRun("outValid pulsed but the model has no OUT value left");
      end else begin
        checkOut(outport, expOut.pop_front());
      end
    end
  end

  initial begin
    #(NumProgs * (RunCycles + ResetCycles + 50) * ClkPeriod);
    failRun("watchdog expired before all programs finished");
  end

  initial begin
    logic [15:0] inVal;
    reset = 1'b1;
    inport = '0;
    lfsr = 32'ha910_9b43;
    for (int p = 0; p < NumProgs; p++) begin
      running = 1'b0;
      buildProgram();
      inVal = takeBits(16);
      runModel(inVal);
      @(posedge clk);
      reset <= 1'b1;
      inport <= inVal;
      repeat (ResetCycles) @(posedge clk);
      reset <= 1'b0;
      outCount = 0;
      running = 1'b1;
      // No redirect or stall can reach fetch in the first three cycles
      for (int k = 0; k < 3; k++) begin
        @(negedge clk);
        checkAddr(instrAddr, 16'(k));
        if (outValid) begin
          failRun("outValid went high before any OUT could reach writeback");
        end
      end
      repeat (RunCycles - 3) @(posedge clk);
      checkCount(outCount, expCount);
    end
    running = 1'b0;
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/executeUnit.sv
rtl/memoryUnit.sv
rtl/pipelineCpu.sv
sim/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
RTL_TOP   ?= pipelineCpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
